// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sd_cmd_top.f \
    --top-module tb_sd_cmd_top \
    -o tb_sd_cmd_top

./obj_dir/tb_sd_cmd_top | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// ==== sd_cmd_top.f ====
verilog/sd_pkg.sv
verilog/sd_crc7.sv
verilog/sd_clk_gen.sv
verilog/sd_cmd_tx.sv
verilog/sd_resp_rx.sv
verilog/sd_cmd_ctrl.sv
verilog/sd_cmd_top.sv
tests/sd_cmd_assert.sv
tests/tb_sd_cmd_top.sv

// ==== tests/sd_cmd_assert.sv ====
`default_nettype none

module sd_cmd_assert (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic done,
    input logic sd_clk,
    input logic cmd_out,
    input logic cmd_oe
);

    timeunit 1ns;
    timeprecision 1ps;

    // Line only driven inside a command
    oe_needs_busy: assert property (
        @(posedge clk) disable iff (!rst_n) cmd_oe |-> busy
    ) else $error("cmd_oe high while busy is low");

    // Single-cycle completion strobe
    done_is_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) done |=> !done
    ) else $error("done high on two consecutive cycles");

    // Card clock parked low between commands
    sd_clk_parked: assert property (
        @(posedge clk) disable iff (!rst_n) !busy |-> !sd_clk
    ) else $error("sd_clk high while busy is low");

    // Released line idles high
    idle_line_high: assert property (
        @(posedge clk) disable iff (!rst_n) !cmd_oe |-> cmd_out
    ) else $error("cmd_out low while cmd_oe is low");

endmodule

`default_nettype wire

// ==== tests/tb_sd_cmd_top.sv ====
`default_nettype none

module tb_sd_cmd_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_cmds   = 200;
    localparam int done_limit = 6000;

    logic         clk;
    logic         rst_n;
    logic         trigger;
    logic [5:0]   cmd_index;
    logic [31:0]  cmd_arg;
    logic         fast_mode;
    logic         cmd_in = 1'b1;
    logic         busy;
    logic         done;
    logic [135:0] resp;
    logic         resp_timeout;
    logic         resp_crc_err;
    logic         sd_clk;
    logic         cmd_out;
    logic         cmd_oe;

    int seed      = 32'h5802_79bc;
    int errors    = 0;
    int done_cnt  = 0;
    int tok_count = 0;

    // Current command and what the card answers
    logic [5:0]   cur_index;
    logic [31:0]  cur_arg;
    logic         cur_fast = 1'b0;
    logic [135:0] rsp_vec;
    logic [7:0]   rsp_len = '0;
    int           rsp_delay;
    logic         rsp_silent = 1'b0;
    logic [135:0] exp_resp;
    logic         exp_timeout;
    logic         exp_crc_err;

    // Card model state
    logic [47:0]  tok = '0;
    int           tok_bits = 0;
    logic         card_active = 1'b0;
    int           card_wait = 0;
    logic [7:0]   card_pos = '0;

    int           phase_len;
    logic         last_sd;
    int           exp_half;

    sd_cmd_top i_sd_cmd_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .trigger      (trigger),
        .cmd_index    (cmd_index),
        .cmd_arg      (cmd_arg),
        .fast_mode    (fast_mode),
        .cmd_in       (cmd_in),
        .busy         (busy),
        .done         (done),
        .resp         (resp),
        .resp_timeout (resp_timeout),
        .resp_crc_err (resp_crc_err),
        .sd_clk       (sd_clk),
        .cmd_out      (cmd_out),
        .cmd_oe       (cmd_oe)
    );

    bind sd_cmd_top sd_cmd_assert i_sd_cmd_assert (
        .clk     (clk),
        .rst_n   (rst_n),
        .busy    (busy),
        .done    (done),
        .sd_clk  (sd_clk),
        .cmd_out (cmd_out),
        .cmd_oe  (cmd_oe)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // ========================================================================
    // Reference model helpers
    // ========================================================================

    // CRC7 over 40 bits, x^7 + x^3 + 1, MSB first
    function automatic logic [6:0] crc7_of(input logic [39:0] d);
        logic [39:0] s;
        logic [6:0]  c;
        logic        fb;
        s = d;
        c = '0;
        repeat (40) begin
            fb = s[39] ^ c[6];
            c  = {c[5:0], 1'b0};
            if (fb) begin
                c = c ^ 7'h09;
            end
            s = s << 1;
        end
        return c;
    endfunction

    task automatic report_err(input string name, input logic [135:0] exp,
                              input logic [135:0] act);
        errors++;
        $display("ERR %s: expected %h, actual %h", name, exp, act);
    endtask

    // Random command, card behaviour and expected outcome
    task automatic pick_command();
        logic [31:0] r;
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] w3;
        logic [39:0] body;
        logic [6:0]  crc;
        logic        no_resp;
        logic        is_long;
        logic        is_r3;
        logic        corrupt;
        r  = $random(seed);
        w0 = $random(seed);
        w1 = $random(seed);
        w2 = $random(seed);
        w3 = $random(seed);
        case (r[2:0])
            3'd0:    cur_index = sd_pkg::cmd_go_idle;
            3'd1:    cur_index = sd_pkg::cmd_all_send_cid;
            3'd2:    cur_index = sd_pkg::cmd_send_csd;
            3'd3:    cur_index = sd_pkg::cmd_send_cid;
            3'd4:    cur_index = sd_pkg::cmd_sd_send_op_cond;
            default: cur_index = r[13:8];
        endcase
        cur_arg    = $random(seed);
        cur_fast   = r[16];
        rsp_silent = (r[22:20] == 3'd0);
        corrupt    = (r[25:24] == 2'd0);
        rsp_delay  = 2 + int'(r[31:28]) % 9;
        no_resp = (cur_index == 6'd0);
        is_long = (cur_index == 6'd2) || (cur_index == 6'd9) || (cur_index == 6'd10);
        is_r3   = (cur_index == 6'd41);
        // R3 carries all ones in the index and CRC fields
        body = {2'b00, is_r3 ? 6'h3f : cur_index, w0};
        crc  = is_r3 ? 7'h7f : crc7_of(body);
        if (corrupt) begin
            crc = crc ^ (7'h40 >> r[18:17]);
        end
        if (no_resp) begin
            rsp_len = 8'd0;
            rsp_vec = '0;
        end else if (is_long) begin
            rsp_len = 8'd136;
            rsp_vec = {2'b00, 6'h3f, w1, w2, w3, w0[31:1], 1'b1};
        end else begin
            rsp_len = 8'd48;
            rsp_vec = {88'b0, body, crc, 1'b1};
        end
        exp_resp    = (no_resp || rsp_silent) ? '0 : rsp_vec;
        exp_timeout = !no_resp && rsp_silent;
        exp_crc_err = !no_resp && !rsp_silent && !is_long && !is_r3 && corrupt;
    endtask

    // ========================================================================
    // Card model
    // ========================================================================

    // Token capture on the card's sampling edge
    always @(posedge sd_clk) begin
        logic [47:0] exp_tok;
        if (cmd_oe) begin
            tok = {tok[46:0], cmd_out};
            tok_bits++;
            if (tok_bits == 48) begin
                exp_tok = {2'b01, cur_index, cur_arg,
                           crc7_of({2'b01, cur_index, cur_arg}), 1'b1};
                if (tok != exp_tok) begin
                    report_err("token", 136'(exp_tok), 136'(tok));
                end
                tok_count++;
                tok_bits = 0;
                if (rsp_len != 8'd0 && !rsp_silent) begin
                    card_active = 1'b1;
                    card_wait   = rsp_delay;
                    card_pos    = rsp_len;
                end
            end
        end
    end

    // Response bits go out on falling edges, end bit leaves the line high
    always @(negedge sd_clk) begin
        if (card_active) begin
            if (card_wait > 0) begin
                card_wait--;
            end else begin
                cmd_in   <= rsp_vec[card_pos - 8'd1];
                card_pos = card_pos - 8'd1;
                if (card_pos == 8'd0) begin
                    card_active = 1'b0;
                end
            end
        end
    end

    // ========================================================================
    // Monitors
    // ========================================================================

    always @(posedge clk) begin
        if (rst_n && done) begin
            done_cnt++;
        end
    end

    // sd_clk half period in clk cycles
    always @(posedge clk) begin
        exp_half = cur_fast ? sd_pkg::half_fast : sd_pkg::half_slow;
        if (!rst_n || !busy) begin
            phase_len = 0;
            last_sd   = sd_clk;
        end else if (sd_clk != last_sd) begin
            if (phase_len != exp_half) begin
                report_err("sd_clk_half", 136'(exp_half), 136'(phase_len));
            end
            phase_len = 1;
            last_sd   = sd_clk;
        end else begin
            phase_len++;
        end
    end

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial begin
        int          i;
        int          n;
        logic        aborted;
        logic        seen;
        logic [31:0] spur;
        rst_n     = 1'b0;
        trigger   = 1'b0;
        cmd_index = '0;
        cmd_arg   = '0;
        fast_mode = 1'b0;
        aborted   = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if (busy || done || cmd_oe || sd_clk || !cmd_out || resp_timeout || resp_crc_err) begin
            errors++;
            $display("Outputs not in their idle state after reset");
        end

        i = 0;
        while (i < num_cmds && !aborted) begin
            pick_command();
            @(posedge clk);
            trigger   <= 1'b1;
            cmd_index <= cur_index;
            cmd_arg   <= cur_arg;
            fast_mode <= cur_fast;
            seen = 1'b0;
            n    = 0;
            while (!seen && n < done_limit) begin
                @(posedge clk);
                n++;
                spur = $random(seed);
                if (done) begin
                    seen = 1'b1;
                end
                // Occasional trigger while busy, must be ignored
                if (busy && !done && spur[5:0] == 6'd0) begin
                    trigger   <= 1'b1;
                    cmd_index <= spur[13:8];
                end else begin
                    trigger <= 1'b0;
                end
            end
            if (!seen) begin
                errors++;
                $display("No done within %0d cycles for command %0d", done_limit, i);
                aborted = 1'b1;
            end else begin
                if (resp != exp_resp) begin
                    report_err("resp", exp_resp, resp);
                end
                if (resp_timeout != exp_timeout) begin
                    report_err("resp_timeout", 136'(exp_timeout), 136'(resp_timeout));
                end
                if (resp_crc_err != exp_crc_err) begin
                    report_err("resp_crc_err", 136'(exp_crc_err), 136'(resp_crc_err));
                end
                repeat (3) @(posedge clk);
                if (done_cnt != i + 1) begin
                    report_err("done_count", 136'(i + 1), 136'(done_cnt));
                end
                if (tok_count != i + 1) begin
                    report_err("token_count", 136'(i + 1), 136'(tok_count));
                end
                if (busy) begin
                    errors++;
                    $display("Controller busy again although no trigger was accepted");
                end
            end
            i++;
        end

        $display("commands: %0d, errors: %0d", i, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/sd_clk_gen.sv ====
`default_nettype none

module sd_clk_gen (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    input  logic fast_mode,
    output logic sd_clk,
    output logic tick_rise,
    output logic tick_fall
);

    typedef logic [$clog2(sd_pkg::half_slow + 1)-1:0] cnt_t;

    cnt_t cnt;
    cnt_t half_m1;
    logic expire;

    // Last cycle of the current half period
    assign half_m1 = fast_mode ? cnt_t'(sd_pkg::half_fast - 1)
                               : cnt_t'(sd_pkg::half_slow - 1);
    assign expire  = run && (cnt == half_m1);

    // Ticks mark the cycle whose closing edge moves sd_clk
    assign tick_rise = expire && !sd_clk;
    assign tick_fall = expire && sd_clk;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sd_clk <= 1'b0;
            cnt    <= '0;
        end else if (!run) begin
            // Parked low, counter waits at zero so the first low phase is full
            sd_clk <= 1'b0;
            cnt    <= '0;
        end else if (expire) begin
            sd_clk <= !sd_clk;
            cnt    <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sd_cmd_ctrl.sv ====
`default_nettype none

module sd_cmd_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               trigger,
    input  logic [5:0]         cmd_index,
    input  logic [31:0]        cmd_arg,
    input  logic               fast_mode_in,
    input  logic               tx_end,
    input  logic               rx_end,
    output logic               busy,
    output logic               done,
    output logic               clk_run,
    output logic               clk_fast,
    output logic               tx_start,
    output logic [5:0]         tx_index,
    output logic [31:0]        tx_arg,
    output logic               rx_start,
    output sd_pkg::resp_kind_e rx_kind
);

    sd_pkg::ctrl_state_e state;
    logic                accept;

    // Response type from the command index
    function automatic sd_pkg::resp_kind_e kind_of(input logic [5:0] idx);
        sd_pkg::resp_kind_e k;
        case (idx)
            sd_pkg::cmd_go_idle:         k = sd_pkg::resp_none;
            sd_pkg::cmd_all_send_cid,
            sd_pkg::cmd_send_csd,
            sd_pkg::cmd_send_cid:        k = sd_pkg::resp_long;
            sd_pkg::cmd_sd_send_op_cond: k = sd_pkg::resp_short_nocrc;
            default:                     k = sd_pkg::resp_short;
        endcase
        return k;
    endfunction

    // Triggers while busy are dropped
    assign accept = (state == sd_pkg::st_idle) && trigger;

    assign busy    = state != sd_pkg::st_idle;
    assign done    = state == sd_pkg::st_done;
    assign clk_run = (state == sd_pkg::st_send) || (state == sd_pkg::st_recv);

    // Receiver is always started, it clears resp for index 0 too
    assign rx_start = (state == sd_pkg::st_send) && tx_end;

    // ========================================================================
    // Request latch
    // ========================================================================

    always_ff @(posedge clk) begin
        if (accept) begin
            tx_index <= cmd_index;
            tx_arg   <= cmd_arg;
        end
    end

    // ========================================================================
    // Sequencer
    // ========================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= sd_pkg::st_idle;
            tx_start <= 1'b0;
            clk_fast <= 1'b0;
            rx_kind  <= sd_pkg::resp_none;
        end else begin
            tx_start <= accept;
            case (state)
                sd_pkg::st_idle: begin
                    if (accept) begin
                        clk_fast <= fast_mode_in;
                        rx_kind  <= kind_of(cmd_index);
                        state    <= sd_pkg::st_send;
                    end
                end
                sd_pkg::st_send: begin
                    if (tx_end) begin
                        state <= (rx_kind == sd_pkg::resp_none) ? sd_pkg::st_done
                                                                : sd_pkg::st_recv;
                    end
                end
                sd_pkg::st_recv: begin
                    if (rx_end) begin
                        state <= sd_pkg::st_done;
                    end
                end
                default: begin
                    state <= sd_pkg::st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sd_cmd_top.sv ====
`default_nettype none

module sd_cmd_top (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         trigger,
    input  logic [5:0]   cmd_index,
    input  logic [31:0]  cmd_arg,
    input  logic         fast_mode,
    input  logic         cmd_in,
    output logic         busy,
    output logic         done,
    output logic [135:0] resp,
    output logic         resp_timeout,
    output logic         resp_crc_err,
    output logic         sd_clk,
    output logic         cmd_out,
    output logic         cmd_oe
);

    logic               clk_run;
    logic               clk_fast;
    logic               tick_rise;
    logic               tick_fall;
    logic               tx_start;
    logic [5:0]         tx_index;
    logic [31:0]        tx_arg;
    logic               tx_end;
    logic               rx_start;
    sd_pkg::resp_kind_e rx_kind;
    logic               rx_end;

    sd_cmd_ctrl i_sd_cmd_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .trigger      (trigger),
        .cmd_index    (cmd_index),
        .cmd_arg      (cmd_arg),
        .fast_mode_in (fast_mode),
        .tx_end       (tx_end),
        .rx_end       (rx_end),
        .busy         (busy),
        .done         (done),
        .clk_run      (clk_run),
        .clk_fast     (clk_fast),
        .tx_start     (tx_start),
        .tx_index     (tx_index),
        .tx_arg       (tx_arg),
        .rx_start     (rx_start),
        .rx_kind      (rx_kind)
    );

    sd_clk_gen i_sd_clk_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (clk_run),
        .fast_mode (clk_fast),
        .sd_clk    (sd_clk),
        .tick_rise (tick_rise),
        .tick_fall (tick_fall)
    );

    sd_cmd_tx i_sd_cmd_tx (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (tx_start),
        .index     (tx_index),
        .arg       (tx_arg),
        .tick_fall (tick_fall),
        .cmd_out   (cmd_out),
        .cmd_oe    (cmd_oe),
        .tx_end    (tx_end)
    );

    sd_resp_rx i_sd_resp_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (rx_start),
        .kind       (rx_kind),
        .tick_rise  (tick_rise),
        .tick_fall  (tick_fall),
        .cmd_in     (cmd_in),
        .resp       (resp),
        .rx_end     (rx_end),
        .rx_timeout (resp_timeout),
        .rx_crc_err (resp_crc_err)
    );

endmodule

`default_nettype wire

// ==== verilog/sd_cmd_tx.sv ====
`default_nettype none

module sd_cmd_tx (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic [5:0]  index,
    input  logic [31:0] arg,
    input  logic        tick_fall,
    output logic        cmd_out,
    output logic        cmd_oe,
    output logic        tx_end
);

    typedef enum logic {
        tx_idle,
        tx_shift
    } tx_state_e;

    tx_state_e   state;
    logic [39:0] shreg;
    logic [5:0]  bit_cnt;
    logic        shift_en;
    logic        at_crc;
    logic        at_end;
    logic        next_bit;
    logic        crc_en;
    logic [6:0]  crc;

    // ========================================================================
    // Bit position
    // ========================================================================

    assign shift_en = (state == tx_shift) && tick_fall;

    // 40 frame bits sent, CRC goes out next
    assign at_crc = bit_cnt == 6'(sd_pkg::cmd_bits - 8);

    // End bit sent, line is released on this tick
    assign at_end = bit_cnt == 6'(sd_pkg::cmd_bits);

    // CRC MSB taken straight from the generator on the first CRC bit
    assign next_bit = at_crc ? crc[6] : shreg[39];

    assign crc_en = shift_en && (bit_cnt < 6'(sd_pkg::cmd_bits - 8));
    assign tx_end = shift_en && at_end;

    sd_crc7 i_sd_crc7 (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (start),
        .bit_en (crc_en),
        .din    (shreg[39]),
        .crc    (crc)
    );

    // ========================================================================
    // Shift register
    // ========================================================================

    always_ff @(posedge clk) begin
        if (start) begin
            // Start bit 0, transmission bit 1
            shreg <= {1'b0, 1'b1, index, arg};
        end else if (shift_en) begin
            if (at_crc) begin
                shreg <= {crc[5:0], 1'b1, 33'b0};
            end else begin
                shreg <= {shreg[38:0], 1'b0};
            end
        end
    end

    // ========================================================================
    // Line control
    // ========================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= tx_idle;
            bit_cnt <= '0;
            cmd_out <= 1'b1;
            cmd_oe  <= 1'b0;
        end else if (start) begin
            state   <= tx_shift;
            bit_cnt <= '0;
        end else if (shift_en) begin
            if (at_end) begin
                cmd_out <= 1'b1;
                cmd_oe  <= 1'b0;
                state   <= tx_idle;
            end else begin
                cmd_out <= next_bit;
                cmd_oe  <= 1'b1;
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sd_crc7.sv ====
`default_nettype none

// Serial CRC7, x^7 + x^3 + 1, MSB first
module sd_crc7 (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear,
    input  logic       bit_en,
    input  logic       din,
    output logic [6:0] crc
);

    logic fb;

    // Feedback taps into bits 0 and 3
    assign fb = din ^ crc[6];

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            crc <= '0;
        end else if (bit_en) begin
            crc <= {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sd_pkg.sv ====
`default_nettype none

package sd_pkg;

    // ========================================================================
    // Timing
    // ========================================================================

    // sd_clk half periods in clk cycles
    localparam int half_slow = 8;
    localparam int half_fast = 1;

    // Token and response lengths in bits
    localparam int cmd_bits        = 48;
    localparam int resp_short_bits = 48;
    localparam int resp_long_bits  = 136;

    // sd_clk cycles to wait for a response start bit
    localparam int ncr_max = 64;

    // ========================================================================
    // Types
    // ========================================================================

    // resp_short_nocrc is the R3 case, CRC field is all ones
    typedef enum logic [1:0] {
        resp_none,
        resp_short,
        resp_long,
        resp_short_nocrc
    } resp_kind_e;

    typedef enum logic [1:0] {
        st_idle,
        st_send,
        st_recv,
        st_done
    } ctrl_state_e;

    // Command indices with a special response kind
    localparam logic [5:0] cmd_go_idle         = 6'd0;
    localparam logic [5:0] cmd_all_send_cid    = 6'd2;
    localparam logic [5:0] cmd_send_csd        = 6'd9;
    localparam logic [5:0] cmd_send_cid        = 6'd10;
    localparam logic [5:0] cmd_sd_send_op_cond = 6'd41;

endpackage

`default_nettype wire

// ==== verilog/sd_resp_rx.sv ====
`default_nettype none

module sd_resp_rx (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  sd_pkg::resp_kind_e     kind,
    input  logic                   tick_rise,
    input  logic                   tick_fall,
    input  logic                   cmd_in,
    output logic [135:0]           resp,
    output logic                   rx_end,
    output logic                   rx_timeout,
    output logic                   rx_crc_err
);

    typedef enum logic [1:0] {
        rx_idle,
        rx_hunt,
        rx_capture,
        rx_finish
    } rx_state_e;

    rx_state_e  state;
    logic [7:0] bit_cnt;
    logic [6:0] hunt_cnt;
    logic [7:0] resp_len;
    logic       start_seen;
    logic       shift_en;
    logic       crc_en;
    logic [6:0] crc;

    assign resp_len = (kind == sd_pkg::resp_long) ? 8'(sd_pkg::resp_long_bits)
                                                  : 8'(sd_pkg::resp_short_bits);

    assign start_seen = (state == rx_hunt) && tick_rise && !cmd_in;
    assign shift_en   = start_seen || ((state == rx_capture) && tick_rise);

    // CRC covers start bit through bit 8
    assign crc_en = start_seen
                 || ((state == rx_capture) && tick_rise && (bit_cnt < 8'd40));

    // Finish on a falling tick so sd_clk is low when the controller stops it
    assign rx_end = (state == rx_finish) && tick_fall;

    sd_crc7 i_sd_crc7 (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (start),
        .bit_en (crc_en),
        .din    (cmd_in),
        .crc    (crc)
    );

    always_ff @(posedge clk) begin
        if (!rst_n || start) begin
            resp <= '0;
        end else if (shift_en) begin
            resp <= {resp[134:0], cmd_in};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= rx_idle;
            bit_cnt    <= '0;
            hunt_cnt   <= '0;
            rx_timeout <= 1'b0;
            rx_crc_err <= 1'b0;
        end else if (start) begin
            // No response expected, flags and resp just get cleared
            state      <= (kind == sd_pkg::resp_none) ? rx_idle : rx_hunt;
            bit_cnt    <= '0;
            hunt_cnt   <= '0;
            rx_timeout <= 1'b0;
            rx_crc_err <= 1'b0;
        end else begin
            case (state)
                rx_hunt: begin
                    if (start_seen) begin
                        bit_cnt <= 8'd1;
                        state   <= rx_capture;
                    end else if (tick_rise) begin
                        if (hunt_cnt == 7'(sd_pkg::ncr_max - 1)) begin
                            rx_timeout <= 1'b1;
                            state      <= rx_finish;
                        end else begin
                            hunt_cnt <= hunt_cnt + 1'b1;
                        end
                    end
                end
                rx_capture: begin
                    if (tick_rise) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == resp_len - 8'd1) begin
                            state <= rx_finish;
                        end
                    end
                end
                rx_finish: begin
                    if (tick_fall) begin
                        // R3 and R2 skip the check
                        rx_crc_err <= !rx_timeout && (kind == sd_pkg::resp_short)
                                   && (crc != resp[7:1]);
                        state      <= rx_idle;
                    end
                end
                default: begin
                    state <= rx_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire
